// ==== logic/pcap_pkg.sv ====
// Shared widths, word and record types, capture and emitter state enums
package pcap_pkg;

    // Output word geometry
    localparam int WORD_BYTES = 8;

    typedef logic [8*WORD_BYTES-1:0] word_t;
    typedef logic [WORD_BYTES-1:0]   keep_t;

    // Frame length counter
    localparam int LEN_W = 16;

    typedef logic [LEN_W-1:0] len_t;

    // Nanoseconds in the upper half, seconds in the lower half
    typedef logic [63:0] ts_t;

    // One committed frame waiting for emission
    typedef struct packed {
        ts_t  ts;
        len_t len;
    } meta_t;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_FRAME,
        CAP_SKIP
    } capture_state_e;

    typedef enum logic [1:0] {
        EMIT_IDLE,
        EMIT_TS,
        EMIT_LEN,
        EMIT_DATA
    } emit_state_e;

endpackage

// ==== logic/pcap_ifs.sv ====
// Capture-to-buffer and buffer-to-emitter interfaces with their modports
`timescale 1ns/1ps

interface capture_if;
    import pcap_pkg::*;

    logic  wr_valid;
    word_t wr_data;
    keep_t wr_keep;
    ts_t   wr_ts;
    len_t  wr_len;
    // Frame verdict, valid together with the final word
    logic  commit;
    logic  discard;

    modport drv (output wr_valid, wr_data, wr_keep, wr_ts, wr_len, commit, discard);
    modport rcv (input  wr_valid, wr_data, wr_keep, wr_ts, wr_len, commit, discard);
endinterface

interface record_if;
    import pcap_pkg::*;

    // Head of the committed record queue
    logic  meta_valid;
    meta_t meta;
    // Word at the buffer read pointer
    word_t rd_data;
    keep_t rd_keep;
    logic  rd_last;
    logic  meta_pop;
    logic  rd_advance;

    modport src (output meta_valid, meta, rd_data, rd_keep, rd_last,
                 input  meta_pop, rd_advance);
    modport snk (input  meta_valid, meta, rd_data, rd_keep, rd_last,
                 output meta_pop, rd_advance);
endinterface

// ==== logic/frame_capture.sv ====
// Capture stage: timestamp sampling, length count, byte packing and frame verdict
`timescale 1ns/1ps

module frame_capture (
    input  logic        axi_clk,
    input  logic        axi_rst,
    input  logic        enable,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    input  logic        rx_last,
    input  logic        rx_error,
    input  logic [31:0] ts_sec,
    input  logic [31:0] ts_nsec,
    output logic        start_packet,
    capture_if.drv      cap
);
    import pcap_pkg::*;

    localparam int LANE_W = $clog2(WORD_BYTES);
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(WORD_BYTES - 1);

    capture_state_e    state;
    logic [LANE_W-1:0] lane;
    word_t             acc_data;
    word_t             word_next;
    keep_t             acc_keep;
    keep_t             keep_next;
    len_t              len_cnt;
    len_t              len_next;
    ts_t               ts_q;
    logic              err_q;
    logic              err_next;
    logic              first_byte;
    logic              take_byte;
    logic              word_done;
    logic              wr_valid_q;
    logic              commit_q;
    logic              discard_q;

    // A frame is accepted only if enable is high on its first byte
    assign first_byte = rx_valid && (state == CAP_IDLE) && enable;
    assign take_byte  = first_byte || (rx_valid && (state == CAP_FRAME));
    assign word_done  = (lane == LAST_LANE) || rx_last;
    assign err_next   = rx_error || (err_q && !first_byte);
    assign len_next   = first_byte ? len_t'(1) : len_cnt + 1'b1;

    // First byte of a word lands in bits 7:0
    always_comb begin
        word_next = (lane == '0) ? '0 : acc_data;
        keep_next = (lane == '0) ? '0 : acc_keep;
        word_next[lane*8 +: 8] = rx_data;
        keep_next[lane]        = 1'b1;
    end

    always_ff @(posedge axi_clk) begin
        if (axi_rst) begin
            state        <= CAP_IDLE;
            lane         <= '0;
            err_q        <= 1'b0;
            start_packet <= 1'b0;
            wr_valid_q   <= 1'b0;
            commit_q     <= 1'b0;
            discard_q    <= 1'b0;
        end else begin
            start_packet <= first_byte;
            wr_valid_q   <= take_byte && word_done;
            commit_q     <= take_byte && rx_last && !err_next;
            discard_q    <= take_byte && rx_last && err_next;
            if (take_byte) begin
                err_q <= err_next;
                lane  <= word_done ? '0 : lane + 1'b1;
            end
            case (state)
                CAP_IDLE: begin
                    if (rx_valid && !rx_last) begin
                        state <= enable ? CAP_FRAME : CAP_SKIP;
                    end
                end
                CAP_FRAME, CAP_SKIP: begin
                    if (rx_valid && rx_last) begin
                        state <= CAP_IDLE;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    // Accumulators stay valid for the cycle after a word completes
    always_ff @(posedge axi_clk) begin
        if (take_byte) begin
            acc_data <= word_next;
            acc_keep <= keep_next;
            len_cnt  <= len_next;
        end
        if (first_byte) begin
            ts_q <= {ts_nsec, ts_sec};
        end
    end

    assign cap.wr_valid = wr_valid_q;
    assign cap.wr_data  = acc_data;
    assign cap.wr_keep  = acc_keep;
    assign cap.wr_ts    = ts_q;
    assign cap.wr_len   = len_cnt;
    assign cap.commit   = commit_q;
    assign cap.discard  = discard_q;

    // Bytes of one frame arrive back to back up to rx_last
    assert property (@(posedge axi_clk) disable iff (axi_rst)
        $rose(rx_valid) |-> (state != CAP_FRAME))
    else $error("rx_valid rose again inside a frame before rx_last");

endmodule

// ==== logic/frame_buffer.sv ====
// Buffer stage: word memory with rollback, committed record queue, frame status pulses
`timescale 1ns/1ps

module frame_buffer #(
    parameter int BUF_WORDS  = 64,
    parameter int META_DEPTH = 8
) (
    input  logic   axi_clk,
    input  logic   axi_rst,
    capture_if.rcv cap,
    record_if.src  rec,
    output logic   good_frame,
    output logic   bad_frame,
    output logic   overflow
);
    import pcap_pkg::*;

    localparam int AW = $clog2(BUF_WORDS);
    localparam int MW = (META_DEPTH > 1) ? $clog2(META_DEPTH) : 1;
    localparam int CW = $clog2(META_DEPTH + 1);
    localparam logic [AW:0]   FULL_WORDS = (AW + 1)'(BUF_WORDS);
    localparam logic [CW-1:0] FULL_META  = CW'(META_DEPTH);

    word_t data_mem [BUF_WORDS];
    keep_t keep_mem [BUF_WORDS];
    logic  last_mem [BUF_WORDS];
    meta_t meta_mem [META_DEPTH];

    // Pointers carry one extra bit to tell full from empty
    logic [AW:0]   wr_ptr;
    logic [AW:0]   wr_ptr_next;
    logic [AW:0]   commit_ptr;
    logic [AW:0]   rd_ptr;
    logic [MW-1:0] meta_wp;
    logic [MW-1:0] meta_rp;
    logic [CW-1:0] meta_cnt;
    logic          drop_q;
    logic          room;
    logic          word_fits;
    logic          meta_full;
    logic          meta_push;
    logic          frame_end;

    function automatic logic [MW-1:0] next_idx(input logic [MW-1:0] idx);
        next_idx = (idx == MW'(META_DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign room        = (wr_ptr - rd_ptr) != FULL_WORDS;
    assign word_fits   = cap.wr_valid && room && !drop_q;
    assign wr_ptr_next = wr_ptr + (AW + 1)'(word_fits);
    assign meta_full   = meta_cnt == FULL_META;
    assign frame_end   = cap.commit || cap.discard;
    // Good frame that kept every word and finds a free record slot
    assign meta_push   = cap.commit && !drop_q && !(cap.wr_valid && !room) && !meta_full;

    always_ff @(posedge axi_clk) begin
        if (word_fits) begin
            data_mem[wr_ptr[AW-1:0]] <= cap.wr_data;
            keep_mem[wr_ptr[AW-1:0]] <= cap.wr_keep;
            last_mem[wr_ptr[AW-1:0]] <= cap.commit;
        end
        if (meta_push) begin
            meta_mem[meta_wp] <= '{ts: cap.wr_ts, len: cap.wr_len};
        end
    end

    always_ff @(posedge axi_clk) begin
        if (axi_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            meta_wp    <= '0;
            meta_rp    <= '0;
            meta_cnt   <= '0;
            drop_q     <= 1'b0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            good_frame <= meta_push;
            bad_frame  <= cap.discard;
            overflow   <= cap.commit && !meta_push;
            if (frame_end) begin
                drop_q <= 1'b0;
                if (meta_push) begin
                    wr_ptr     <= wr_ptr_next;
                    commit_ptr <= wr_ptr_next;
                end else begin
                    // Roll back to the start of the frame
                    wr_ptr <= commit_ptr;
                end
            end else begin
                wr_ptr <= wr_ptr_next;
                if (cap.wr_valid && !room) begin
                    drop_q <= 1'b1;
                end
            end
            if (rec.rd_advance) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (meta_push) begin
                meta_wp <= next_idx(meta_wp);
            end
            if (rec.meta_pop) begin
                meta_rp <= next_idx(meta_rp);
            end
            if (meta_push && !rec.meta_pop) begin
                meta_cnt <= meta_cnt + 1'b1;
            end else if (!meta_push && rec.meta_pop) begin
                meta_cnt <= meta_cnt - 1'b1;
            end
        end
    end

    assign rec.meta_valid = meta_cnt != '0;
    assign rec.meta       = meta_mem[meta_rp];
    assign rec.rd_data    = data_mem[rd_ptr[AW-1:0]];
    assign rec.rd_keep    = keep_mem[rd_ptr[AW-1:0]];
    assign rec.rd_last    = last_mem[rd_ptr[AW-1:0]];

    // Emitter only reads words of committed frames
    assert property (@(posedge axi_clk) disable iff (axi_rst)
        rec.rd_advance |-> (rd_ptr != commit_ptr))
    else $error("read pointer passed the committed pointer");

    assert property (@(posedge axi_clk) disable iff (axi_rst)
        rec.meta_pop |-> rec.meta_valid)
    else $error("record popped from an empty queue");

endmodule

// ==== logic/record_emitter.sv ====
// Emitter stage: record FSM sending timestamp, length and data words, plus busy
`timescale 1ns/1ps

module record_emitter (
    input  logic            axi_clk,
    input  logic            axi_rst,
    record_if.snk           rec,
    output pcap_pkg::word_t m_tdata,
    output pcap_pkg::keep_t m_tkeep,
    output logic            m_tvalid,
    output logic            m_tlast,
    input  logic            m_tready,
    output logic            busy
);
    import pcap_pkg::*;

    emit_state_e state;
    emit_state_e state_next;
    word_t       len_word;
    logic        accept;

    assign accept = m_tvalid && m_tready;

    // Length zero-extended to 32 bits, repeated in both halves
    assign len_word = {{(32 - LEN_W){1'b0}}, rec.meta.len, {(32 - LEN_W){1'b0}}, rec.meta.len};

    // Header is done once the length word goes out
    assign rec.meta_pop   = (state == EMIT_LEN) && accept;
    assign rec.rd_advance = (state == EMIT_DATA) && accept;

    assign busy = rec.meta_valid || (state != EMIT_IDLE);

    // Outputs depend only on state and buffer head, so they hold without accept
    always_comb begin
        m_tvalid = state != EMIT_IDLE;
        m_tdata  = rec.meta.ts;
        m_tkeep  = '1;
        m_tlast  = 1'b0;
        case (state)
            EMIT_LEN: begin
                m_tdata = len_word;
            end
            EMIT_DATA: begin
                m_tdata = rec.rd_data;
                m_tkeep = rec.rd_keep;
                m_tlast = rec.rd_last;
            end
            default: begin
                m_tdata = rec.meta.ts;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            EMIT_IDLE: begin
                if (rec.meta_valid) begin
                    state_next = EMIT_TS;
                end
            end
            EMIT_TS: begin
                if (accept) begin
                    state_next = EMIT_LEN;
                end
            end
            EMIT_LEN: begin
                if (accept) begin
                    state_next = EMIT_DATA;
                end
            end
            EMIT_DATA: begin
                // Next record follows directly when one is waiting
                if (accept && rec.rd_last) begin
                    state_next = rec.meta_valid ? EMIT_TS : EMIT_IDLE;
                end
            end
            default: state_next = EMIT_IDLE;
        endcase
    end

    always_ff @(posedge axi_clk) begin
        if (axi_rst) begin
            state <= EMIT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assert property (@(posedge axi_clk) disable iff (axi_rst)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata)))
    else $error("m_tdata changed while stalled");

endmodule

// ==== logic/pcap_capture_top.sv ====
// Top level: plain ports, buffer parameters and the capture, buffer and emitter stages
`timescale 1ns/1ps

module pcap_capture_top #(
    parameter int BUF_WORDS  = 64,
    parameter int META_DEPTH = 8
) (
    input  logic            axi_clk,
    input  logic            axi_rst,
    input  logic            enable,
    input  logic [7:0]      rx_data,
    input  logic            rx_valid,
    input  logic            rx_last,
    input  logic            rx_error,
    input  logic [31:0]     ts_sec,
    input  logic [31:0]     ts_nsec,
    output logic            start_packet,
    output logic            good_frame,
    output logic            bad_frame,
    output logic            overflow,
    output logic            busy,
    output pcap_pkg::word_t m_tdata,
    output pcap_pkg::keep_t m_tkeep,
    output logic            m_tvalid,
    output logic            m_tlast,
    input  logic            m_tready
);

    capture_if cap_bus ();
    record_if  rec_bus ();

    frame_capture i_frame_capture (
        .axi_clk      (axi_clk),
        .axi_rst      (axi_rst),
        .enable       (enable),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_last      (rx_last),
        .rx_error     (rx_error),
        .ts_sec       (ts_sec),
        .ts_nsec      (ts_nsec),
        .start_packet (start_packet),
        .cap          (cap_bus)
    );

    frame_buffer #(
        .BUF_WORDS  (BUF_WORDS),
        .META_DEPTH (META_DEPTH)
    ) i_frame_buffer (
        .axi_clk    (axi_clk),
        .axi_rst    (axi_rst),
        .cap        (cap_bus),
        .rec        (rec_bus),
        .good_frame (good_frame),
        .bad_frame  (bad_frame),
        .overflow   (overflow)
    );

    record_emitter i_record_emitter (
        .axi_clk  (axi_clk),
        .axi_rst  (axi_rst),
        .rec      (rec_bus),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tvalid (m_tvalid),
        .m_tlast  (m_tlast),
        .m_tready (m_tready),
        .busy     (busy)
    );

endmodule

// ==== tb/pcap_checker.sv ====
// Checker: reference record builder, buffer occupancy model, pulse, busy and stream comparison
`timescale 1ns/1ps

module pcap_checker #(
    parameter int BUF_WORDS  = 64,
    parameter int META_DEPTH = 8
) (
    input  logic            axi_clk,
    input  logic            axi_rst,
    input  logic            enable,
    input  logic [7:0]      rx_data,
    input  logic            rx_valid,
    input  logic            rx_last,
    input  logic            rx_error,
    input  logic [31:0]     ts_sec,
    input  logic [31:0]     ts_nsec,
    input  logic            start_packet,
    input  logic            good_frame,
    input  logic            bad_frame,
    input  logic            overflow,
    input  logic            busy,
    input  pcap_pkg::word_t m_tdata,
    input  pcap_pkg::keep_t m_tkeep,
    input  logic            m_tvalid,
    input  logic            m_tlast,
    input  logic            m_tready,
    input  logic            final_check,
    output int              value_errs,
    output int              other_errs
);
    import pcap_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    word_t   exp_data [$];
    keep_t   exp_keep [$];
    logic    exp_last [$];
    byte_q_t cur_bytes;
    ts_t     cur_ts;
    logic    cur_err;
    logic    in_frame;
    logic    skipping;
    logic    start_d1;
    // Bit 1 is the value due on this sample
    logic [1:0] good_d;
    logic [1:0] bad_d;
    logic [1:0] ovf_d;
    int      words_used;
    int      recs_used;
    int      pending;
    int      beat;
    int      n_value = 0;
    int      n_other = 0;

    assign value_errs = n_value;
    assign other_errs = n_other;

    // Record layout: timestamp word, length word, then bytes packed from lane 0 up
    function automatic void build_record(input byte_q_t bytes, input ts_t ts, input int len);
        word_t w;
        keep_t k;
        w = '0;
        k = '0;
        exp_data.push_back(ts);
        exp_keep.push_back('1);
        exp_last.push_back(1'b0);
        exp_data.push_back({16'h0, len[15:0], 16'h0, len[15:0]});
        exp_keep.push_back('1);
        exp_last.push_back(1'b0);
        for (int i = 0; i < len; i++) begin
            if (i % 8 == 0) begin
                w = '0;
                k = '0;
            end
            w[(i % 8) * 8 +: 8] = bytes[i];
            k[i % 8] = 1'b1;
            if (i % 8 == 7 || i == len - 1) begin
                exp_data.push_back(w);
                exp_keep.push_back(k);
                exp_last.push_back(i == len - 1);
            end
        end
    endfunction

    task automatic check_bit(input string name, input logic seen, input logic exp);
        if (seen !== exp) begin
            n_value++;
            $display("Fail %0t: %s is %b, expected %b", $time, name, seen, exp);
        end
    endtask

    task automatic compare_stream();
        word_t ed;
        keep_t ek;
        logic  el;
        if (m_tvalid && m_tready) begin
            if (exp_data.size() == 0) begin
                n_other++;
                $display("Output stream sent a word at %0t although no record was expected", $time);
            end else begin
                ed = exp_data.pop_front();
                ek = exp_keep.pop_front();
                el = exp_last.pop_front();
                if (m_tdata !== ed || m_tkeep !== ek || m_tlast !== el) begin
                    n_value++;
                    $display("Fail %0t: word %0d is %h keep %h last %b, expected %h keep %h last %b",
                             $time, beat, m_tdata, m_tkeep, m_tlast, ed, ek, el);
                end
                // Header done after the length word, data words free buffer space
                if (beat == 1) begin
                    recs_used--;
                end else if (beat >= 2) begin
                    words_used--;
                end
                if (el) begin
                    beat = 0;
                    pending--;
                end else begin
                    beat++;
                end
            end
        end
    endtask

    task automatic close_frame();
        int nwords;
        nwords = (cur_bytes.size() + 7) / 8;
        if (cur_err) begin
            bad_d[0] = 1'b1;
        end else if (words_used + nwords <= BUF_WORDS && recs_used < META_DEPTH) begin
            good_d[0] = 1'b1;
            words_used += nwords;
            recs_used++;
            build_record(cur_bytes, cur_ts, cur_bytes.size());
        end else begin
            ovf_d[0] = 1'b1;
        end
    endtask

    task automatic track_input();
        if (rx_valid) begin
            if (in_frame) begin
                cur_bytes.push_back(rx_data);
                cur_err = cur_err | rx_error;
            end else if (skipping) begin
                skipping = !rx_last;
            end else if (enable) begin
                in_frame = 1'b1;
                start_d1 = 1'b1;
                cur_bytes.delete();
                cur_bytes.push_back(rx_data);
                cur_err = rx_error;
                cur_ts  = {ts_nsec, ts_sec};
            end else begin
                skipping = !rx_last;
            end
            if (in_frame && rx_last) begin
                close_frame();
                in_frame = 1'b0;
            end
        end
    endtask

    always @(posedge axi_clk) begin
        if (axi_rst) begin
            exp_data.delete();
            exp_keep.delete();
            exp_last.delete();
            in_frame   = 1'b0;
            skipping   = 1'b0;
            start_d1   = 1'b0;
            good_d     = '0;
            bad_d      = '0;
            ovf_d      = '0;
            words_used = 0;
            recs_used  = 0;
            pending    = 0;
            beat       = 0;
        end else begin
            check_bit("start_packet", start_packet, start_d1);
            check_bit("good_frame", good_frame, good_d[1]);
            check_bit("bad_frame", bad_frame, bad_d[1]);
            check_bit("overflow", overflow, ovf_d[1]);
            // Committed record becomes visible together with good_frame
            if (good_d[1]) begin
                pending++;
            end
            check_bit("busy", busy, pending != 0);
            if (pending == 0) begin
                check_bit("m_tvalid", m_tvalid, 1'b0);
            end
            start_d1 = 1'b0;
            good_d   = {good_d[0], 1'b0};
            bad_d    = {bad_d[0], 1'b0};
            ovf_d    = {ovf_d[0], 1'b0};
            compare_stream();
            track_input();
            if (final_check && exp_data.size() != 0) begin
                n_other++;
                $display("Run ended with %0d expected record words never sent", exp_data.size());
            end
        end
    end

endmodule

// ==== tb/tb_pcap_capture.sv ====
// Testbench top: clock, reset, frame stimulus, ready driver, watchdog, DUT and checker
`timescale 1ns/1ps

module tb_pcap_capture;
    import pcap_pkg::*;

    localparam int BUF_WORDS    = 64;
    localparam int META_DEPTH   = 8;
    localparam int MAX_FRAMES   = 48;
    localparam int MAX_LEN      = 200;
    localparam int MAX_GAP      = 8;
    localparam int READY_LOW    = 0;
    localparam int READY_HIGH   = 1;
    localparam int READY_RANDOM = 2;
    // All stimulus bytes and the longest records, four times over
    localparam int WATCHDOG_CYCLES =
        (MAX_FRAMES * (MAX_LEN + MAX_GAP) + MAX_FRAMES * (2 + MAX_LEN / 8)) * 4;

    logic        axi_clk = 1'b0;
    logic        axi_rst;
    logic        enable;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_last;
    logic        rx_error;
    logic [31:0] ts_sec;
    logic [31:0] ts_nsec;
    logic        start_packet;
    logic        good_frame;
    logic        bad_frame;
    logic        overflow;
    logic        busy;
    word_t       m_tdata;
    keep_t       m_tkeep;
    logic        m_tvalid;
    logic        m_tlast;
    logic        m_tready;
    logic        final_check;
    int          value_errs;
    int          other_errs;
    int          ready_mode;
    integer      seed = 54546;

    // Word boundary cases, then the overflow sequence for a 64 word buffer
    int edge_lens [6]  = '{1, 7, 8, 9, 16, 200};
    int ovf_lens  [10] = '{120, 120, 120, 200, 8, 8, 8, 8, 8, 16};

    always #4 axi_clk = ~axi_clk;

    always @(posedge axi_clk) begin
        ts_nsec <= ts_nsec + 32'd8;
        ts_sec  <= ts_sec + 32'd1;
    end

    always @(posedge axi_clk) begin
        case (ready_mode)
            READY_LOW:  m_tready <= 1'b0;
            READY_HIGH: m_tready <= 1'b1;
            default:    m_tready <= (($random(seed) & 3) != 0);
        endcase
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge axi_clk);
    endtask

    // Enable only matters on the first byte, so it is raised for the rest
    task automatic send_frame(input int len, input int err_at, input logic en);
        for (int i = 0; i < len; i++) begin
            @(posedge axi_clk);
            enable   <= (i == 0) ? en : 1'b1;
            rx_valid <= 1'b1;
            rx_data  <= 8'($random(seed));
            rx_last  <= (i == len - 1);
            rx_error <= (i == err_at);
        end
        @(posedge axi_clk);
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
        rx_error <= 1'b0;
    endtask

    task automatic random_frame(input logic with_err);
        int len;
        int err_at;
        len    = 1 + int'($unsigned($random(seed)) % MAX_LEN);
        err_at = with_err ? int'($unsigned($random(seed)) % len) : -1;
        send_frame(len, err_at, 1'b1);
        wait_cycles(int'($unsigned($random(seed)) % MAX_GAP));
    endtask

    task automatic drain_records();
        wait_cycles(4);
        while (busy) begin
            @(posedge axi_clk);
        end
    endtask

    pcap_capture_top #(
        .BUF_WORDS  (BUF_WORDS),
        .META_DEPTH (META_DEPTH)
    ) i_pcap_capture_top (
        .axi_clk      (axi_clk),
        .axi_rst      (axi_rst),
        .enable       (enable),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_last      (rx_last),
        .rx_error     (rx_error),
        .ts_sec       (ts_sec),
        .ts_nsec      (ts_nsec),
        .start_packet (start_packet),
        .good_frame   (good_frame),
        .bad_frame    (bad_frame),
        .overflow     (overflow),
        .busy         (busy),
        .m_tdata      (m_tdata),
        .m_tkeep      (m_tkeep),
        .m_tvalid     (m_tvalid),
        .m_tlast      (m_tlast),
        .m_tready     (m_tready)
    );

    pcap_checker #(
        .BUF_WORDS  (BUF_WORDS),
        .META_DEPTH (META_DEPTH)
    ) i_pcap_checker (
        .axi_clk      (axi_clk),
        .axi_rst      (axi_rst),
        .enable       (enable),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_last      (rx_last),
        .rx_error     (rx_error),
        .ts_sec       (ts_sec),
        .ts_nsec      (ts_nsec),
        .start_packet (start_packet),
        .good_frame   (good_frame),
        .bad_frame    (bad_frame),
        .overflow     (overflow),
        .busy         (busy),
        .m_tdata      (m_tdata),
        .m_tkeep      (m_tkeep),
        .m_tvalid     (m_tvalid),
        .m_tlast      (m_tlast),
        .m_tready     (m_tready),
        .final_check  (final_check),
        .value_errs   (value_errs),
        .other_errs   (other_errs)
    );

    initial begin
        axi_rst     = 1'b1;
        enable      = 1'b0;
        rx_data     = 8'h00;
        rx_valid    = 1'b0;
        rx_last     = 1'b0;
        rx_error    = 1'b0;
        ts_sec      = 32'h5000_0000;
        ts_nsec     = 32'h0;
        m_tready    = 1'b0;
        final_check = 1'b0;
        ready_mode  = READY_HIGH;
        repeat (8) @(posedge axi_clk);
        axi_rst <= 1'b0;
        foreach (edge_lens[i]) begin
            send_frame(edge_lens[i], -1, 1'b1);
            wait_cycles(3);
        end
        repeat (8) random_frame(1'b0);
        // Bad frames between good ones
        repeat (4) begin
            random_frame(1'b1);
            random_frame(1'b0);
        end
        ready_mode <= READY_RANDOM;
        repeat (12) random_frame(($random(seed) & 7) == 0);
        // Frames that start with enable low, one of them a single byte
        send_frame(40, -1, 1'b0);
        send_frame(1, -1, 1'b0);
        send_frame(12, -1, 1'b1);
        send_frame(30, -1, 1'b0);
        drain_records();
        // Stalled output fills the buffer and the record queue
        ready_mode <= READY_LOW;
        foreach (ovf_lens[i]) begin
            send_frame(ovf_lens[i], -1, 1'b1);
            wait_cycles(2);
        end
        wait_cycles(40);
        ready_mode <= READY_RANDOM;
        drain_records();
        @(posedge axi_clk);
        final_check <= 1'b1;
        @(posedge axi_clk);
        final_check <= 1'b0;
        @(posedge axi_clk);
        $display("Checks done with %0d value errors and %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("Timeout after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/pcap_pkg.sv
logic/pcap_ifs.sv
logic/frame_capture.sv
logic/frame_buffer.sv
logic/record_emitter.sv
logic/pcap_capture_top.sv
tb/pcap_checker.sv
tb/tb_pcap_capture.sv

// ==== Bender.yml ====
package:
  name: pcap_capture

sources:
  - files:
      - logic/pcap_pkg.sv
      - logic/pcap_ifs.sv
      - logic/frame_capture.sv
      - logic/frame_buffer.sv
      - logic/record_emitter.sv
      - logic/pcap_capture_top.sv
  - target: test
    files:
      - tb/pcap_checker.sv
      - tb/tb_pcap_capture.sv
